// ==== verilog.f ====
+incdir+include
source/isaPkg.sv
source/execPkg.sv
source/opDecoder.sv
source/aluCore.sv
source/branchResolver.sv
source/resultStage.sv
source/executeUnit.sv
verification/executeTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := executeTb
RTL_TOP    := executeUnit
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/executeTb.sv ====
// Directed testbench of the execute unit covering ALU forms, carry chain, jumps,
// operand sources, kill and unknown opcodes, and writeback stall
`timescale 1ns/1ps
`include "execute_defs.svh"

module executeTb;
	import execPkg::*;

	localparam int clkPeriod = 8;
	localparam int numTests = 7;
	localparam int resultTimeout = 20;
	// Model codes 0..7 follow the group extension order
	localparam int modelNot = 8;
	localparam int modelNeg = 9;
	localparam int modelInc = 10;
	localparam int modelDec = 11;
	localparam int modelMov = 12;
	localparam int modelNone = 13;

	logic        clk = 1'b0;
	logic        rstN;
	logic        issue;
	logic        wbStall;
	execReqT     req;
	logic        execValid;
	execResultT  execOut;
	logic [63:0] rflags;

	integer      seed = 3000;
	int          testErrors;
	int          testsPassed;
	int          testsFailed;
	logic [63:0] modelFlags;
	execResultT  outQ[$];
	logic [63:0] flagQ[$];

	executeUnit dut_i (
		.clk(clk), .rstN(rstN), .issue(issue), .req(req), .wbStall(wbStall),
		.execValid(execValid), .execOut(execOut), .rflags(rflags)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Items are taken where execValid is high and writeback is not stalled
	always @(negedge clk) begin
		if (rstN && execValid && !wbStall) begin
			outQ.push_back(execOut);
			flagQ.push_back(rflags);
		end
	end

	initial begin
		#(numTests * 200 * clkPeriod);
		$display("Timeout: the tests did not finish in the expected time");
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			testErrors++;
		end
	endtask

	function automatic execReqT makeReq(input logic [7:0] opcode, input logic hasExt,
		input logic [2:0] ext, input logic [63:0] a, input logic [63:0] b,
		input logic [63:0] imm);
		execReqT r;
		r = '0;
		r.rip = rand64();
		r.opcode = opcode;
		r.hasExt = hasExt;
		r.extOpcode = ext;
		r.instrLen = 4'd3;
		r.operand1 = a;
		r.operand2 = b;
		r.imm = imm;
		r.destReg = 4'($random(seed));
		r.destRegValid = 1'b1;
		return r;
	endfunction

	function automatic execResultT okItem(input execReqT r, input logic [63:0] res);
		execResultT e;
		e = '0;
		e.execOk = 1'b1;
		e.result = res;
		e.destReg = r.destReg;
		e.destRegValid = r.destRegValid;
		return e;
	endfunction

	// x86 condition of a Jcc low nibble with odd codes negated
	function automatic logic condHolds(input logic [3:0] cc, input logic [63:0] f);
		logic sfNeOf;
		logic base;
		sfNeOf = f[`FLAG_SF] != f[`FLAG_OF];
		case (cc[3:1])
			3'd0: base = f[`FLAG_OF];
			3'd1: base = f[`FLAG_CF];
			3'd2: base = f[`FLAG_ZF];
			3'd3: base = f[`FLAG_CF] || f[`FLAG_ZF];
			3'd4: base = f[`FLAG_SF];
			3'd5: base = f[`FLAG_PF];
			3'd6: base = sfNeOf;
			default: base = f[`FLAG_ZF] || sfNeOf;
		endcase
		return base != cc[0];
	endfunction

	// Reference result that also updates the flag model in program order
	task automatic predict(input int op, input logic [63:0] a, input logic [63:0] b,
		output logic [63:0] res);
		logic [64:0] wide;
		logic        cf;
		logic        of;
		logic        cIn;
		cIn = modelFlags[`FLAG_CF];
		cf = 1'b0;
		of = 1'b0;
		res = b;
		case (op)
			0, 2: begin
				wide = {1'b0, a} + {1'b0, b} + 65'(op == 2 && cIn);
				res = wide[63:0];
				cf = wide[64];
				of = (a[63] == b[63]) && (res[63] != a[63]);
			end
			3, 5, 7: begin
				res = a - b - 64'(op == 3 && cIn);
				cf = (a < b) || (a == b && op == 3 && cIn);
				of = (a[63] != b[63]) && (res[63] != a[63]);
			end
			1: res = a | b;
			4: res = a & b;
			6: res = a ^ b;
			modelNot: res = ~a;
			modelNeg: begin
				res = 64'd0 - a;
				cf = (a != 64'd0);
				of = (a == 64'h8000_0000_0000_0000);
			end
			modelInc: begin
				res = a + 64'd1;
				of = (a == 64'h7FFF_FFFF_FFFF_FFFF);
			end
			modelDec: begin
				res = a - 64'd1;
				of = (a == 64'h8000_0000_0000_0000);
			end
			default: res = b;
		endcase
		if (op <= modelDec && op != modelNot) begin
			modelFlags[`FLAG_ZF] = (res == 64'd0);
			modelFlags[`FLAG_SF] = res[63];
			modelFlags[`FLAG_PF] = ($countones(res[7:0]) % 2 == 0);
			modelFlags[`FLAG_OF] = of;
			if (op != modelInc && op != modelDec) begin
				modelFlags[`FLAG_CF] = cf;
			end
		end
	endtask

	// Called and returns 1 ns after a rising edge
	task automatic issueOp(input execReqT r);
		req = r;
		issue = 1'b1;
		@(posedge clk);
		#1;
		issue = 1'b0;
	endtask

	task automatic waitResult(output execResultT res, output logic [63:0] flags);
		int cycles;
		cycles = 0;
		while (outQ.size() == 0 && cycles < resultTimeout) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (outQ.size() == 0) begin
			$display("No result came out of the DUT within %0d cycles", resultTimeout);
			testErrors++;
			res = '0;
			flags = '0;
		end else begin
			res = outQ.pop_front();
			flags = flagQ.pop_front();
		end
	endtask

	task automatic checkItem(input string name, input execResultT expected,
		input logic [63:0] expFlags, input bit checkResult);
		execResultT  got;
		logic [63:0] gotFlags;
		waitResult(got, gotFlags);
		checkValue({name, " execOk"}, 64'(got.execOk), 64'(expected.execOk));
		if (checkResult) begin
			checkValue({name, " result"}, got.result, expected.result);
		end
		checkValue({name, " destReg"}, 64'(got.destReg), 64'(expected.destReg));
		checkValue({name, " destRegValid"}, 64'(got.destRegValid),
			64'(expected.destRegValid));
		checkValue({name, " didJump"}, 64'(got.didJump), 64'(expected.didJump));
		checkValue({name, " jumpTarget"}, got.jumpTarget, expected.jumpTarget);
		checkValue({name, " kill"}, 64'(got.kill), 64'(expected.kill));
		checkValue({name, " rflags"}, gotFlags, expFlags);
	endtask

	task automatic runOne(input string name, input execReqT r, input int op,
		input logic [63:0] a, input logic [63:0] b);
		logic [63:0] res;
		logic [63:0] expFlags;
		predict(op, a, b, res);
		expFlags = modelFlags;
		issueOp(r);
		checkItem(name, okItem(r, res), expFlags, op != 7 && op != modelNone);
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			$display("%s: ok", name);
			testsPassed++;
		end else begin
			$display("%s: %0d errors", name, testErrors);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	task automatic aluFormsTest();
		execReqT     r;
		logic [63:0] a;
		logic [63:0] b;
		for (int ext = 0; ext < 8; ext++) begin
			for (int form = 0; form < 5; form++) begin
				a = rand64();
				b = rand64();
				case (form)
					0: r = makeReq({2'b00, 3'(ext), 3'b001}, 1'b0, 3'd0, a, b, rand64());
					1: r = makeReq({2'b00, 3'(ext), 3'b011}, 1'b0, 3'd0, a, b, rand64());
					2: r = makeReq({2'b00, 3'(ext), 3'b101}, 1'b0, 3'd0, a, rand64(), b);
					3: r = makeReq(8'h81, 1'b1, 3'(ext), a, rand64(), b);
					default: begin
						// Byte immediate arrives sign-extended
						b = {{56{b[7]}}, b[7:0]};
						r = makeReq(8'h83, 1'b1, 3'(ext), a, rand64(), b);
					end
				endcase
				runOne($sformatf("alu op %0d form %0d", ext, form), r, ext, a, b);
			end
		end
		finishTest("arithmetic and logic forms");
	endtask

	task automatic carryChainTest();
		execReqT     r[3];
		logic [63:0] a[3];
		logic [63:0] b[3];
		logic [63:0] res[3];
		logic [63:0] flags[3];
		int          ops[3];
		// ADD with a carry out, then ADC and SBB issued back to back
		ops = '{0, 2, 3};
		for (int i = 0; i < 3; i++) begin
			a[i] = rand64();
			b[i] = rand64();
		end
		a[0] = 64'hFFFF_FFFF_FFFF_FFF0;
		b[0] = b[0] | 64'h8000_0000_0000_0000;
		for (int i = 0; i < 3; i++) begin
			r[i] = makeReq({2'b00, 3'(ops[i]), 3'b001}, 1'b0, 3'd0, a[i], b[i], 64'd0);
			predict(ops[i], a[i], b[i], res[i]);
			flags[i] = modelFlags;
		end
		for (int i = 0; i < 3; i++) begin
			issueOp(r[i]);
		end
		for (int i = 0; i < 3; i++) begin
			checkItem($sformatf("chain %0d", i), okItem(r[i], res[i]), flags[i], 1'b1);
		end
		finishTest("carry chain");
	endtask

	task automatic jumpTest();
		execReqT     r;
		execResultT  e;
		logic [63:0] presetA[4];
		logic [63:0] presetB[4];
		int          presetOp[4];
		logic [7:0]  byteImm;
		logic        taken;
		// Equal, borrow, signed overflow of CMP and of ADD
		presetA = '{64'd5, 64'd3, 64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF};
		presetB = '{64'd5, 64'd5, 64'd1, 64'd1};
		presetOp = '{7, 7, 7, 0};
		for (int p = 0; p < 4; p++) begin
			r = makeReq({2'b00, 3'(presetOp[p]), 3'b001}, 1'b0, 3'd0, presetA[p],
				presetB[p], 64'd0);
			runOne($sformatf("preset %0d", p), r, presetOp[p], presetA[p], presetB[p]);
			for (int cc = 0; cc < 16; cc++) begin
				byteImm = 8'($random(seed));
				r = makeReq(8'h70 + 8'(cc), 1'b0, 3'd0, rand64(), rand64(),
					{{56{byteImm[7]}}, byteImm});
				r.instrLen = 4'd2;
				taken = condHolds(4'(cc), modelFlags);
				e = okItem(r, 64'd0);
				e.didJump = taken;
				e.jumpTarget = taken ? r.rip + 64'(r.instrLen) + r.imm : 64'd0;
				issueOp(r);
				checkItem($sformatf("preset %0d jcc %0d", p, cc), e, modelFlags, 1'b0);
			end
		end
		finishTest("conditional jumps");
	endtask

	task automatic operandSourceTest();
		execReqT     r;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] m;
		a = rand64();
		b = rand64();
		m = rand64();
		r = makeReq(8'h01, 1'b0, 3'd0, a, b, 64'd0);
		r.memSrc1 = 1'b1;
		r.memData = m;
		runOne("add from memory", r, 0, m, b);
		r = makeReq(8'h2B, 1'b0, 3'd0, a, b, 64'd0);
		r.memSrc2 = 1'b1;
		r.memData = m;
		runOne("sub from memory", r, 5, a, m);
		r = makeReq(8'h8B, 1'b0, 3'd0, a, b, 64'd0);
		r.memSrc2 = 1'b1;
		r.memData = m;
		runOne("mov load", r, modelMov, a, m);
		runOne("mov register", makeReq(8'h89, 1'b0, 3'd0, a, b, 64'd0), modelMov, a, b);
		runOne("mov B8+r", makeReq(8'hBB, 1'b0, 3'd0, a, b, m), modelMov, a, m);
		runOne("mov C7", makeReq(8'hC7, 1'b1, 3'd0, a, b, m), modelMov, a, m);
		runOne("not", makeReq(8'hF7, 1'b1, 3'd2, a, b, 64'd0), modelNot, a, b);
		runOne("neg", makeReq(8'hF7, 1'b1, 3'd3, a, b, 64'd0), modelNeg, a, b);
		// Borrow sets CF, which INC and DEC must keep
		runOne("borrow", makeReq(8'h2B, 1'b0, 3'd0, 64'd3, 64'd5, 64'd0), 5, 64'd3, 64'd5);
		a = 64'h7FFF_FFFF_FFFF_FFFF;
		runOne("inc", makeReq(8'hFF, 1'b1, 3'd0, a, b, 64'd0), modelInc, a, b);
		a = 64'h8000_0000_0000_0000;
		runOne("dec", makeReq(8'hFF, 1'b1, 3'd1, a, b, 64'd0), modelDec, a, b);
		runOne("nop", makeReq(8'h90, 1'b0, 3'd0, a, b, 64'd0), modelNone, a, b);
		finishTest("operand sources");
	endtask

	task automatic killUnknownTest();
		execReqT    r;
		execResultT e;
		logic [7:0] codes[5];
		logic [2:0] exts[5];
		// Three returns, then HLT and the dropped F7 /4 multiply
		codes = '{8'hC3, 8'hCB, 8'hCF, 8'hF4, 8'hF7};
		exts = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd4};
		for (int i = 0; i < 5; i++) begin
			r = makeReq(codes[i], 1'b1, exts[i], rand64(), rand64(), 64'd0);
			e = okItem(r, 64'd0);
			e.execOk = (i < 3);
			e.kill = (i < 3);
			issueOp(r);
			checkItem($sformatf("opcode %h", codes[i]), e, modelFlags, 1'b0);
		end
		finishTest("kill and unknown");
	endtask

	task automatic stallTest();
		execReqT     r[2];
		logic [63:0] a[2];
		logic [63:0] b[2];
		logic [63:0] res[2];
		logic [63:0] flags[2];
		execResultT  held;
		logic [63:0] heldFlags;
		for (int i = 0; i < 2; i++) begin
			a[i] = rand64();
			b[i] = rand64();
			r[i] = makeReq({2'b00, 3'(i * 5), 3'b001}, 1'b0, 3'd0, a[i], b[i], 64'd0);
			predict(i * 5, a[i], b[i], res[i]);
			flags[i] = modelFlags;
		end
		issueOp(r[0]);
		issueOp(r[1]);
		// First item at the output and second one in the decoder
		wbStall = 1'b1;
		held = execOut;
		heldFlags = rflags;
		checkValue("stalled result", held.result, res[0]);
		repeat (4) begin
			@(posedge clk);
			#1;
			checkValue("execValid in stall", 64'(execValid), 64'd1);
			checkValue("execOut.result in stall", execOut.result, held.result);
			checkValue("rflags in stall", rflags, heldFlags);
		end
		wbStall = 1'b0;
		checkItem("after stall 0", okItem(r[0], res[0]), flags[0], 1'b1);
		checkItem("after stall 1", okItem(r[1], res[1]), flags[1], 1'b1);
		// No third item may follow the two
		@(posedge clk);
		#1;
		checkValue("items left after stall", 64'(outQ.size()), 64'd0);
		finishTest("writeback stall");
	endtask

	initial begin
		rstN = 1'b0;
		issue = 1'b0;
		wbStall = 1'b0;
		req = '0;
		modelFlags = `FLAGS_RESET;
		testErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkValue("rflags after reset", rflags, `FLAGS_RESET);
		checkValue("execValid after reset", 64'(execValid), 64'd0);
		checkValue("execOk after reset", 64'(execOut.execOk), 64'd0);
		checkValue("didJump after reset", 64'(execOut.didJump), 64'd0);
		checkValue("kill after reset", 64'(execOut.kill), 64'd0);
		finishTest("reset");
		aluFormsTest();
		carryChainTest();
		jumpTest();
		operandSourceTest();
		killUnknownTest();
		stallTest();
		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end
endmodule

// ==== source/executeUnit.sv ====
// Top of the two-stage execute unit for the small x86-64 pipeline
// Issue is a one-cycle strobe; results appear two edges later unless stalled
`timescale 1ns/1ps
`include "execute_defs.svh"

module executeUnit (
	input  logic                clk,
	input  logic                rstN,
	input  logic                issue,
	input  execPkg::execReqT    req,
	input  logic                wbStall,
	output logic                execValid,
	output execPkg::execResultT execOut,
	output logic [63:0]         rflags
);
	import execPkg::*;

	decodedT               decoded;
	logic                  decValid;
	aluOutT                aluOut;
	logic                  taken;
	logic [`RIP_WIDTH-1:0] target;

	opDecoder decoder_i (
		.clk(clk), .rstN(rstN), .issue(issue), .wbStall(wbStall),
		.req(req), .decoded(decoded), .decValid(decValid)
	);

	// Carry for ADC and SBB comes from the committed flags
	aluCore alu_i (
		.decoded(decoded), .carryIn(rflags[`FLAG_CF]), .aluOut(aluOut)
	);

	branchResolver branch_i (
		.decoded(decoded), .rflags(rflags), .taken(taken), .target(target)
	);

	resultStage result_i (
		.clk(clk), .rstN(rstN), .wbStall(wbStall), .decoded(decoded),
		.decValid(decValid), .aluOut(aluOut), .taken(taken), .target(target),
		.execOut(execOut), .execValid(execValid), .rflags(rflags)
	);
endmodule

// ==== source/resultStage.sv ====
// Second stage: derives ZF, SF and PF, owns RFLAGS and registers the output
// record; everything holds while writeback stalls
`timescale 1ns/1ps
`include "execute_defs.svh"

module resultStage (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  wbStall,
	input  execPkg::decodedT      decoded,
	input  logic                  decValid,
	input  execPkg::aluOutT       aluOut,
	input  logic                  taken,
	input  logic [`RIP_WIDTH-1:0] target,
	output execPkg::execResultT   execOut,
	output logic                  execValid,
	output logic [63:0]           rflags
);
	import execPkg::*;

	logic        updateFlags;
	logic [63:0] nextFlags;

	assign updateFlags = decValid && decoded.known && decoded.writesFlags;

	always_comb begin
		nextFlags = rflags;
		nextFlags[`FLAG_ZF] = (aluOut.result == '0);
		nextFlags[`FLAG_SF] = aluOut.result[`DATA_WIDTH-1];
		// PF looks at the low byte only
		nextFlags[`FLAG_PF] = ~^aluOut.result[7:0];
		nextFlags[`FLAG_OF] = aluOut.overflow;
		if (!decoded.keepsCarry) begin
			nextFlags[`FLAG_CF] = aluOut.carry;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rflags <= `FLAGS_RESET;
			execValid <= 1'b0;
			execOut <= '0;
		end else if (!wbStall) begin
			execValid <= decValid;
			if (updateFlags) begin
				rflags <= nextFlags;
			end
			execOut.execOk <= decValid && decoded.known;
			execOut.result <= aluOut.result;
			execOut.destReg <= decoded.destReg;
			execOut.destRegValid <= decoded.destRegValid;
			execOut.didJump <= decValid && taken;
			execOut.jumpTarget <= taken ? target : '0;
			execOut.kill <= decValid && decoded.isKill;
		end
	end

	// Decoder never marks a return as a jump
	assert property (@(posedge clk) disable iff (!rstN)
		!(execOut.didJump && execOut.kill));
endmodule

// ==== source/branchResolver.sv ====
// Evaluates the Jcc short condition against RFLAGS and forms the target
// Combinational, read by resultStage in the execute cycle
`timescale 1ns/1ps
`include "execute_defs.svh"

module branchResolver (
	input  execPkg::decodedT      decoded,
	input  logic [63:0]           rflags,
	output logic                  taken,
	output logic [`RIP_WIDTH-1:0] target
);
	import isaPkg::*;

	logic baseCond;
	logic sfNeOf;

	assign sfNeOf = rflags[`FLAG_SF] ^ rflags[`FLAG_OF];

	// Condition of the even code of each pair
	always_comb begin
		case (decoded.cond)
			condO, condNo: baseCond = rflags[`FLAG_OF];
			condB, condNb: baseCond = rflags[`FLAG_CF];
			condE, condNe: baseCond = rflags[`FLAG_ZF];
			condBe, condA: baseCond = rflags[`FLAG_CF] | rflags[`FLAG_ZF];
			condS, condNs: baseCond = rflags[`FLAG_SF];
			condP, condNp: baseCond = rflags[`FLAG_PF];
			condL, condGe: baseCond = sfNeOf;
			condLe, condG: baseCond = rflags[`FLAG_ZF] | sfNeOf;
			default: baseCond = 1'b0;
		endcase
	end

	// Odd codes are the negation
	assign taken = decoded.isJump && (baseCond ^ decoded.cond[0]);

	// Relative to the next instruction
	assign target = decoded.rip
		+ {{(`RIP_WIDTH - `INSTR_LEN_WIDTH){1'b0}}, decoded.instrLen}
		+ decoded.imm;
endmodule

// ==== source/aluCore.sv ====
// Arithmetic and logic of the execute cycle; combinational
// Produces the 64-bit result with x86 carry and overflow for resultStage
`timescale 1ns/1ps
`include "execute_defs.svh"

module aluCore (
	input  execPkg::decodedT decoded,
	input  logic             carryIn,
	output execPkg::aluOutT  aluOut
);
	import isaPkg::*;

	logic [`DATA_WIDTH-1:0] lhs;
	logic [`DATA_WIDTH-1:0] rhs;
	logic                   cin;
	logic                   subtract;
	logic                   arith;
	logic [`DATA_WIDTH:0]   wide;
	logic [`DATA_WIDTH-1:0] logicRes;
	logic                   lhsSign;
	logic                   rhsSign;
	logic                   resSign;

	// Operand shaping for the shared adder
	always_comb begin
		lhs = decoded.opA;
		rhs = decoded.opB;
		cin = 1'b0;
		subtract = 1'b0;
		arith = 1'b1;
		logicRes = '0;
		case (decoded.aluOp)
			aluAdd: subtract = 1'b0;
			aluAdc: cin = carryIn;
			aluSub: subtract = 1'b1;
			aluSbb: begin
				subtract = 1'b1;
				cin = carryIn;
			end
			// 0 - opA borrows exactly when opA is nonzero, which is CF of NEG
			aluNeg: begin
				lhs = '0;
				rhs = decoded.opA;
				subtract = 1'b1;
			end
			aluInc: rhs = `DATA_WIDTH'(1);
			aluDec: begin
				rhs = `DATA_WIDTH'(1);
				subtract = 1'b1;
			end
			default: begin
				arith = 1'b0;
				case (decoded.aluOp)
					aluAnd: logicRes = decoded.opA & decoded.opB;
					aluOr: logicRes = decoded.opA | decoded.opB;
					aluXor: logicRes = decoded.opA ^ decoded.opB;
					aluNot: logicRes = ~decoded.opA;
					default: logicRes = decoded.opB;
				endcase
			end
		endcase
	end

	// Top bit is the carry of a sum or the borrow of a difference
	always_comb begin
		if (subtract) begin
			wide = {1'b0, lhs} - {1'b0, rhs} - {{`DATA_WIDTH{1'b0}}, cin};
		end else begin
			wide = {1'b0, lhs} + {1'b0, rhs} + {{`DATA_WIDTH{1'b0}}, cin};
		end
	end

	assign lhsSign = lhs[`DATA_WIDTH-1];
	assign rhsSign = rhs[`DATA_WIDTH-1];
	assign resSign = wide[`DATA_WIDTH-1];

	always_comb begin
		aluOut.result = arith ? wide[`DATA_WIDTH-1:0] : logicRes;
		aluOut.carry = arith && wide[`DATA_WIDTH];
		if (!arith) begin
			aluOut.overflow = 1'b0;
		end else if (subtract) begin
			// Signs differ and the result left the sign of lhs
			aluOut.overflow = (lhsSign != rhsSign) && (resSign != lhsSign);
		end else begin
			aluOut.overflow = (lhsSign == rhsSign) && (resSign != lhsSign);
		end
	end
endmodule

// ==== source/opDecoder.sv ====
// First stage: captures an issued instruction, selects its operands and
// decodes opcode plus ModRM extension into an operation class
`timescale 1ns/1ps

module opDecoder (
	input  logic             clk,
	input  logic             rstN,
	input  logic             issue,
	input  logic             wbStall,
	input  execPkg::execReqT req,
	output execPkg::decodedT decoded,
	output logic             decValid
);
	import isaPkg::*;
	import execPkg::*;

	opcodeT   op;
	groupExtT grp;
	logic     aluForm;
	logic     useImm;
	decodedT  nextDec;

	always_comb begin
		op = opcodeT'(req.opcode);
		// ALU rows carry the operation in opcode bits 5:3
		grp = groupExtT'(req.opcode[5:3]);
		aluForm = 1'b0;
		useImm = 1'b0;
		nextDec = '0;
		if (req.opcode inside {[opMovRiFirst:opMovRiLast]}) begin
			nextDec.known = 1'b1;
			useImm = 1'b1;
		end else if (req.opcode inside {[opJccFirst:opJccLast]}) begin
			nextDec.known = 1'b1;
			nextDec.isJump = 1'b1;
			nextDec.cond = condT'(req.opcode[3:0]);
		end else begin
			case (op)
				opNop, opMovRm, opMovMr: nextDec.known = 1'b1;
				opMovImm: begin
					nextDec.known = req.hasExt && (req.extOpcode == 3'd0);
					useImm = 1'b1;
				end
				opAddRm, opAddMr, opOrRm, opOrMr, opAdcRm, opAdcMr, opSbbRm, opSbbMr,
				opAndRm, opAndMr, opSubRm, opSubMr, opXorRm, opXorMr, opCmpRm, opCmpMr:
					aluForm = 1'b1;
				opAddAi, opOrAi, opAdcAi, opSbbAi, opAndAi, opSubAi, opXorAi, opCmpAi: begin
					aluForm = 1'b1;
					useImm = 1'b1;
				end
				opGrp1Iv, opGrp1Ib: begin
					aluForm = req.hasExt;
					grp = groupExtT'(req.extOpcode);
					useImm = 1'b1;
				end
				opGrp3: begin
					// F7 /2 is NOT and leaves the flags alone, /3 is NEG
					if (req.hasExt && req.extOpcode == 3'd2) begin
						nextDec.known = 1'b1;
						nextDec.aluOp = aluNot;
					end else if (req.hasExt && req.extOpcode == 3'd3) begin
						nextDec.known = 1'b1;
						nextDec.aluOp = aluNeg;
						nextDec.writesFlags = 1'b1;
					end
				end
				opGrp5: begin
					// FF /0 INC, /1 DEC, both preserve CF
					if (req.hasExt && req.extOpcode[2:1] == 2'b00) begin
						nextDec.known = 1'b1;
						nextDec.aluOp = req.extOpcode[0] ? aluDec : aluInc;
						nextDec.writesFlags = 1'b1;
						nextDec.keepsCarry = 1'b1;
					end
				end
				opRet, opRetFar, opIret: begin
					nextDec.known = 1'b1;
					nextDec.isKill = 1'b1;
				end
				default: nextDec.known = 1'b0;
			endcase
		end
		if (aluForm) begin
			nextDec.known = 1'b1;
			nextDec.writesFlags = 1'b1;
			case (grp)
				extAdd: nextDec.aluOp = aluAdd;
				extOr: nextDec.aluOp = aluOr;
				extAdc: nextDec.aluOp = aluAdc;
				extSbb: nextDec.aluOp = aluSbb;
				extAnd: nextDec.aluOp = aluAnd;
				extXor: nextDec.aluOp = aluXor;
				// CMP subtracts and only the flags are kept downstream
				extSub, extCmp: nextDec.aluOp = aluSub;
				default: nextDec.aluOp = aluPassB;
			endcase
		end
		nextDec.opA = req.memSrc1 ? req.memData : req.operand1;
		if (req.memSrc2) begin
			nextDec.opB = req.memData;
		end else begin
			nextDec.opB = useImm ? req.imm : req.operand2;
		end
		nextDec.rip = req.rip;
		nextDec.instrLen = req.instrLen;
		nextDec.imm = req.imm;
		nextDec.destReg = req.destReg;
		nextDec.destRegValid = req.destRegValid;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else if (!wbStall) begin
			decValid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (!wbStall) begin
			decoded <= nextDec;
		end
	end

	// Single memory read port per instruction
	assert property (@(posedge clk) disable iff (!rstN)
		issue |-> !(req.memSrc1 && req.memSrc2));
endmodule

// ==== source/execPkg.sv ====
// Records passed between the execute stages and across the unit's ports
// Decoded fields use the operation and condition types of isaPkg
package execPkg;
	`include "execute_defs.svh"

	typedef struct packed {
		logic [`RIP_WIDTH-1:0]        rip;
		logic [`OPCODE_WIDTH-1:0]     opcode;
		logic                         hasExt;
		logic [`EXT_OPCODE_WIDTH-1:0] extOpcode;
		logic [`INSTR_LEN_WIDTH-1:0]  instrLen;
		logic [`DATA_WIDTH-1:0]       operand1;
		logic [`DATA_WIDTH-1:0]       operand2;
		logic                         memSrc1;
		logic                         memSrc2;
		logic [`DATA_WIDTH-1:0]       memData;
		// Sign-extended before issue
		logic [`DATA_WIDTH-1:0]       imm;
		logic [`REG_CODE_WIDTH-1:0]   destReg;
		logic                         destRegValid;
	} execReqT;

	typedef struct packed {
		logic                         known;
		isaPkg::aluOpT                aluOp;
		logic                         writesFlags;
		logic                         keepsCarry;
		logic                         isJump;
		isaPkg::condT                 cond;
		logic                         isKill;
		logic [`DATA_WIDTH-1:0]       opA;
		logic [`DATA_WIDTH-1:0]       opB;
		logic [`RIP_WIDTH-1:0]        rip;
		logic [`INSTR_LEN_WIDTH-1:0]  instrLen;
		logic [`DATA_WIDTH-1:0]       imm;
		logic [`REG_CODE_WIDTH-1:0]   destReg;
		logic                         destRegValid;
	} decodedT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] result;
		logic                   carry;
		logic                   overflow;
	} aluOutT;

	typedef struct packed {
		logic                       execOk;
		logic [`DATA_WIDTH-1:0]     result;
		logic [`REG_CODE_WIDTH-1:0] destReg;
		logic                       destRegValid;
		logic                       didJump;
		logic [`RIP_WIDTH-1:0]      jumpTarget;
		logic                       kill;
	} execResultT;
endpackage

// ==== source/isaPkg.sv ====
// Instruction set encodings of the execute unit: opcodes, group extensions,
// ALU operation classes and Jcc conditions
package isaPkg;
	`include "execute_defs.svh"

	// Kept one-byte opcodes; ranges are given by their first and last value
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opAddRm = 8'h01, opAddMr = 8'h03, opAddAi = 8'h05,
		opOrRm = 8'h09, opOrMr = 8'h0B, opOrAi = 8'h0D,
		opAdcRm = 8'h11, opAdcMr = 8'h13, opAdcAi = 8'h15,
		opSbbRm = 8'h19, opSbbMr = 8'h1B, opSbbAi = 8'h1D,
		opAndRm = 8'h21, opAndMr = 8'h23, opAndAi = 8'h25,
		opSubRm = 8'h29, opSubMr = 8'h2B, opSubAi = 8'h2D,
		opXorRm = 8'h31, opXorMr = 8'h33, opXorAi = 8'h35,
		opCmpRm = 8'h39, opCmpMr = 8'h3B, opCmpAi = 8'h3D,
		opJccFirst = 8'h70, opJccLast = 8'h7F,
		opGrp1Iv = 8'h81, opGrp1Ib = 8'h83,
		opMovRm = 8'h89, opMovMr = 8'h8B, opNop = 8'h90,
		opMovRiFirst = 8'hB8, opMovRiLast = 8'hBF,
		opRet = 8'hC3, opMovImm = 8'hC7, opRetFar = 8'hCB, opIret = 8'hCF,
		opGrp3 = 8'hF7, opGrp5 = 8'hFF
	} opcodeT;

	// ModRM reg field of 81/83, same order as opcode bits 5:3 of the ALU rows
	typedef enum logic [`EXT_OPCODE_WIDTH-1:0] {
		extAdd, extOr, extAdc, extSbb, extAnd, extSub, extXor, extCmp
	} groupExtT;

	typedef enum logic [3:0] {
		aluPassB, aluAdd, aluAdc, aluSub, aluSbb, aluAnd,
		aluOr, aluXor, aluNot, aluNeg, aluInc, aluDec
	} aluOpT;

	// Low nibble of 70..7F, odd codes negate the even one before them
	typedef enum logic [3:0] {
		condO, condNo, condB, condNb, condE, condNe, condBe, condA,
		condS, condNs, condP, condNp, condL, condGe, condLe, condG
	} condT;
endpackage

// ==== include/execute_defs.svh ====
// Widths, flag bit positions and the flags reset value of the execute unit
// Included by both packages and by every RTL file that sizes a signal
`ifndef EXECUTE_DEFS_SVH
`define EXECUTE_DEFS_SVH

// Datapath widths
`define DATA_WIDTH        64
`define RIP_WIDTH         64
`define OPCODE_WIDTH      8
`define EXT_OPCODE_WIDTH  3
`define REG_CODE_WIDTH    4
`define INSTR_LEN_WIDTH   4

// Bit positions inside RFLAGS
`define FLAG_CF  0
`define FLAG_PF  2
`define FLAG_ZF  6
`define FLAG_SF  7
`define FLAG_OF  11

// Reserved bit 1 always reads as one
`define FLAGS_RESET  64'h2

`endif
